// ==== logic/pwm_chain_pkg.sv ====
// Timing and channel constants for the PWM chain datapath.
// Imported by the control unit, the counter, the comparator, the dead-time
// generators and the top level.

package pwm_chain_pkg;

    // Width of count, thresholds, limits and phase shift
    localparam int counter_width = 16;

    // PWM channels sharing one timebase
    localparam int n_channels = 3;

    // Width of a dead-time value in clock cycles
    localparam int deadtime_width = 16;

    // Counter mode codes
    localparam logic [2:0] mode_up = 3'd0;
    localparam logic [2:0] mode_down = 3'd1;
    localparam logic [2:0] mode_updown = 3'd2;

endpackage

// ==== logic/chain_regs_pkg.sv ====
// Register map of the PWM chain control unit.
// Bus widths, byte offsets of every register and the control-register fields.

package chain_regs_pkg;

    localparam int bus_width = 32;
    localparam logic [31:0] base_address = 32'h0000_0000;

    // Compare thresholds, one low and one high per channel
    localparam logic [31:0] reg_cmp_low_0 = 32'h00;
    localparam logic [31:0] reg_cmp_low_1 = 32'h04;
    localparam logic [31:0] reg_cmp_low_2 = 32'h08;
    localparam logic [31:0] reg_cmp_high_0 = 32'h0C;
    localparam logic [31:0] reg_cmp_high_1 = 32'h10;
    localparam logic [31:0] reg_cmp_high_2 = 32'h14;

    // Dead time per channel
    localparam logic [31:0] reg_deadtime_0 = 32'h18;
    localparam logic [31:0] reg_deadtime_1 = 32'h1C;
    localparam logic [31:0] reg_deadtime_2 = 32'h20;

    // Timebase limits and phase
    localparam logic [31:0] reg_start = 32'h24;
    localparam logic [31:0] reg_stop = 32'h28;
    localparam logic [31:0] reg_shift = 32'h2C;

    localparam logic [31:0] reg_out_enable = 32'h30;
    localparam logic [31:0] reg_dt_enable = 32'h34;
    localparam logic [31:0] reg_control = 32'h38;

    // Control register fields
    localparam int ctl_mode_lsb = 0;
    localparam int ctl_dc_bit = 3;
    localparam int ctl_run_bit = 4;

endpackage

// ==== logic/chain_control_unit.sv ====
// Register file of the PWM chain, written over the simple strobe bus.
// Each write is latched, applied one cycle later, and sb_ready returns high
// the cycle after that. Timing registers are locked while the counter runs.

`timescale 1ns/10ps

module chain_control_unit import pwm_chain_pkg::*, chain_regs_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic counter_running,
    input  logic [bus_width-1:0] sb_address,
    input  logic [bus_width-1:0] sb_write_data,
    input  logic sb_write_strobe,
    output logic sb_ready,
    output logic counter_run,
    output logic [2:0] counter_mode,
    output logic [counter_width-1:0] counter_start,
    output logic [counter_width-1:0] counter_stop,
    output logic [counter_width-1:0] timebase_shift,
    output logic [counter_width-1:0] thr_low [n_channels],
    output logic [counter_width-1:0] thr_high [n_channels],
    output logic [deadtime_width-1:0] deadtime [n_channels],
    output logic [n_channels-1:0] deadtime_enable,
    output logic [1:0] out_enable [n_channels]
);

    typedef enum logic {
        idle_state,
        act_state
    } state_t;

    state_t state;
    logic act_done;
    logic apply_write;
    logic dc_mode;

    logic [bus_width-1:0] latched_address;
    logic [bus_width-1:0] latched_data;
    logic [counter_width-1:0] wr_value;

    assign apply_write = (state == act_state) && !act_done;
    assign wr_value = latched_data[counter_width-1:0];

    // Capture address and data of an accepted write
    always_ff @(posedge clock) begin
        if (state == idle_state && sb_write_strobe) begin
            latched_address <= sb_address;
            latched_data <= sb_write_data;
        end
    end

    // Act state lasts two cycles: apply, then release the bus
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle_state;
            act_done <= 1'b0;
            sb_ready <= 1'b1;
        end else begin
            case (state)
                idle_state: begin
                    act_done <= 1'b0;
                    if (sb_write_strobe) begin
                        sb_ready <= 1'b0;
                        state <= act_state;
                    end
                end
                act_state: begin
                    act_done <= 1'b1;
                    if (act_done) begin
                        sb_ready <= 1'b1;
                        state <= idle_state;
                    end
                end
                default: state <= idle_state;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_run <= 1'b0;
            counter_mode <= mode_up;
            counter_start <= '0;
            counter_stop <= '1;
            timebase_shift <= '0;
            deadtime_enable <= '0;
            dc_mode <= 1'b0;
            for (int i = 0; i < n_channels; i++) begin
                thr_low[i] <= '0;
                thr_high[i] <= '1;
                deadtime[i] <= '0;
                out_enable[i] <= 2'b00;
            end
        end else if (apply_write) begin
            case (latched_address)
                base_address + reg_cmp_low_0: thr_low[0] <= wr_value;
                base_address + reg_cmp_low_1: thr_low[1] <= wr_value;
                base_address + reg_cmp_low_2: thr_low[2] <= wr_value;
                base_address + reg_cmp_high_0: thr_high[0] <= wr_value;
                base_address + reg_cmp_high_1: thr_high[1] <= wr_value;
                base_address + reg_cmp_high_2: thr_high[2] <= wr_value;
                base_address + reg_deadtime_0: begin
                    if (!counter_running) deadtime[0] <= latched_data[deadtime_width-1:0];
                end
                base_address + reg_deadtime_1: begin
                    if (!counter_running) deadtime[1] <= latched_data[deadtime_width-1:0];
                end
                base_address + reg_deadtime_2: begin
                    if (!counter_running) deadtime[2] <= latched_data[deadtime_width-1:0];
                end
                base_address + reg_start: begin
                    if (!counter_running) begin
                        counter_start <= wr_value;
                        // Duty-cycle mode pins every window to the counter limits
                        if (dc_mode) begin
                            for (int i = 0; i < n_channels; i++) begin
                                thr_low[i] <= wr_value;
                            end
                        end
                    end
                end
                base_address + reg_stop: begin
                    if (!counter_running) begin
                        counter_stop <= wr_value;
                        if (dc_mode) begin
                            for (int i = 0; i < n_channels; i++) begin
                                thr_high[i] <= wr_value;
                            end
                        end
                    end
                end
                base_address + reg_shift: begin
                    if (!counter_running) timebase_shift <= wr_value;
                end
                base_address + reg_out_enable: begin
                    for (int i = 0; i < n_channels; i++) begin
                        out_enable[i] <= latched_data[2*i +: 2];
                    end
                end
                base_address + reg_dt_enable: deadtime_enable <= latched_data[n_channels-1:0];
                base_address + reg_control: begin
                    // Run bit stays writable so a running counter can be stopped
                    counter_run <= latched_data[ctl_run_bit];
                    if (!counter_running) begin
                        dc_mode <= latched_data[ctl_dc_bit];
                        if (latched_data[ctl_dc_bit]) begin
                            counter_mode <= mode_updown;
                        end else begin
                            counter_mode <= latched_data[ctl_mode_lsb +: 3];
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/pwm_counter.sv ====
// Shared timebase of the PWM chain.
// Counts up, down or up-down between the start and stop limits while run is
// high. The phase shift offsets the first count after start.

`timescale 1ns/10ps

module pwm_counter import pwm_chain_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic counter_run,
    input  logic [2:0] counter_mode,
    input  logic [counter_width-1:0] counter_start,
    input  logic [counter_width-1:0] counter_stop,
    input  logic [counter_width-1:0] timebase_shift,
    output logic [counter_width-1:0] count,
    output logic counter_running
);

    // Up-down direction, high while counting up
    logic count_up;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            counter_running <= 1'b0;
            count_up <= 1'b1;
        end else if (!counter_running) begin
            if (counter_run) begin
                counter_running <= 1'b1;
                count_up <= 1'b1;
                if (counter_mode == mode_down) begin
                    count <= counter_stop - timebase_shift;
                end else begin
                    count <= counter_start + timebase_shift;
                end
            end
        end else if (!counter_run) begin
            counter_running <= 1'b0;
            count <= counter_start;
        end else begin
            case (counter_mode)
                mode_up: begin
                    count <= (count >= counter_stop) ? counter_start : count + 1'b1;
                end
                mode_down: begin
                    count <= (count <= counter_start) ? counter_stop : count - 1'b1;
                end
                mode_updown: begin
                    // Turn at either limit without dwelling on it
                    if (count_up) begin
                        if (count >= counter_stop) begin
                            count_up <= 1'b0;
                            count <= count - 1'b1;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end else begin
                        if (count <= counter_start) begin
                            count_up <= 1'b1;
                            count <= count + 1'b1;
                        end else begin
                            count <= count - 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== logic/pwm_comparator.sv ====
// Window comparator for all PWM channels.
// A channel is high while the shared count lies in [thr_low, thr_high).
// The result is registered, one cycle behind the count.

`timescale 1ns/10ps

module pwm_comparator import pwm_chain_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic [counter_width-1:0] count,
    input  logic [counter_width-1:0] thr_low [n_channels],
    input  logic [counter_width-1:0] thr_high [n_channels],
    output logic [n_channels-1:0] pwm_raw
);

    logic [n_channels-1:0] in_window;

    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            in_window[i] = (count >= thr_low[i]) && (count < thr_high[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_raw <= '0;
        end else begin
            pwm_raw <= in_window;
        end
    end

endmodule

// ==== logic/deadtime_generator.sv ====
// Complementary gate driver for one PWM channel.
// The side that turns on waits until raw has held its level for deadtime
// cycles; the side that turns off follows raw at once. Enables mask each side.

`timescale 1ns/10ps

module deadtime_generator import pwm_chain_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic pwm_raw_bit,
    input  logic [deadtime_width-1:0] deadtime,
    input  logic deadtime_enable,
    input  logic [1:0] out_enable,
    output logic gate_high,
    output logic gate_low
);

    logic raw_prev;
    logic [deadtime_width-1:0] held_cycles;
    logic [deadtime_width-1:0] elapsed;
    logic settled;

    // Cycles raw has spent at its present level before this one
    assign elapsed = (pwm_raw_bit != raw_prev) ? '0 : held_cycles;
    assign settled = !deadtime_enable || (elapsed >= deadtime);

    always_ff @(posedge clock) begin
        if (!reset) begin
            raw_prev <= 1'b0;
            held_cycles <= '0;
            gate_high <= 1'b0;
            gate_low <= 1'b0;
        end else begin
            raw_prev <= pwm_raw_bit;
            if (pwm_raw_bit != raw_prev) begin
                held_cycles <= deadtime_width'(1);
            end else if (held_cycles != '1) begin
                held_cycles <= held_cycles + 1'b1;
            end
            gate_high <= out_enable[0] && pwm_raw_bit && settled;
            gate_low <= out_enable[1] && !pwm_raw_bit && settled;
        end
    end

endmodule

// ==== logic/pwm_chain.sv ====
// Top level of the three-channel PWM chain.
// Bus writes program the control unit, which drives the shared counter,
// the window comparator and one dead-time generator per channel.

`timescale 1ns/10ps

module pwm_chain import pwm_chain_pkg::*, chain_regs_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic [bus_width-1:0] sb_address,
    input  logic [bus_width-1:0] sb_write_data,
    input  logic sb_write_strobe,
    output logic sb_ready,
    output logic [n_channels-1:0] gate_high,
    output logic [n_channels-1:0] gate_low
);

    logic counter_run;
    logic counter_running;
    logic [2:0] counter_mode;
    logic [counter_width-1:0] counter_start;
    logic [counter_width-1:0] counter_stop;
    logic [counter_width-1:0] timebase_shift;
    logic [counter_width-1:0] count;
    logic [counter_width-1:0] thr_low [n_channels];
    logic [counter_width-1:0] thr_high [n_channels];
    logic [deadtime_width-1:0] deadtime [n_channels];
    logic [n_channels-1:0] deadtime_enable;
    logic [1:0] out_enable [n_channels];
    logic [n_channels-1:0] pwm_raw;

    chain_control_unit control_inst (
        .clock(clock),
        .reset(reset),
        .counter_running(counter_running),
        .sb_address(sb_address),
        .sb_write_data(sb_write_data),
        .sb_write_strobe(sb_write_strobe),
        .sb_ready(sb_ready),
        .counter_run(counter_run),
        .counter_mode(counter_mode),
        .counter_start(counter_start),
        .counter_stop(counter_stop),
        .timebase_shift(timebase_shift),
        .thr_low(thr_low),
        .thr_high(thr_high),
        .deadtime(deadtime),
        .deadtime_enable(deadtime_enable),
        .out_enable(out_enable)
    );

    pwm_counter counter_inst (
        .clock(clock),
        .reset(reset),
        .counter_run(counter_run),
        .counter_mode(counter_mode),
        .counter_start(counter_start),
        .counter_stop(counter_stop),
        .timebase_shift(timebase_shift),
        .count(count),
        .counter_running(counter_running)
    );

    pwm_comparator comparator_inst (
        .clock(clock),
        .reset(reset),
        .count(count),
        .thr_low(thr_low),
        .thr_high(thr_high),
        .pwm_raw(pwm_raw)
    );

    for (genvar i = 0; i < n_channels; i++) begin : channel
        deadtime_generator deadtime_inst (
            .clock(clock),
            .reset(reset),
            .pwm_raw_bit(pwm_raw[i]),
            .deadtime(deadtime[i]),
            .deadtime_enable(deadtime_enable[i]),
            .out_enable(out_enable[i]),
            .gate_high(gate_high[i]),
            .gate_low(gate_low[i])
        );
    end

endmodule

// ==== bench/pwm_chain_tb.sv ====
// Testbench for the three-channel PWM chain.
// Programs the chain over the register bus from a table of settings and
// expected gate widths, then counts gate cycles over one period per row.

`timescale 1ns/10ps

module pwm_chain_tb import pwm_chain_pkg::*, chain_regs_pkg::*; ();

    localparam int clock_period = 40;
    localparam int n_rows = 8;
    localparam int bus_cycles_per_row = 100;

    // One row per test, expected values per channel
    typedef struct packed {
        logic [15:0] start;
        logic [15:0] stop;
        logic [15:0] mode;
        logic [0:n_channels-1][15:0] low;
        logic [0:n_channels-1][15:0] high;
        logic [15:0] deadtime;
        logic [15:0] dt_enable;
        logic [15:0] out_enable;
        logic [15:0] dc;
        logic [15:0] period;
        logic [0:n_channels-1][15:0] exp_high;
        logic [0:n_channels-1][15:0] exp_low;
    } test_row_t;

    logic clock;
    logic reset;
    logic [bus_width-1:0] sb_address;
    logic [bus_width-1:0] sb_write_data;
    logic sb_write_strobe;
    logic sb_ready;
    logic [n_channels-1:0] gate_high;
    logic [n_channels-1:0] gate_low;

    test_row_t rows [n_rows];
    string row_names [n_rows];
    int high_seen [n_channels];
    int low_seen [n_channels];
    int error_count = 0;
    int failed_tests = 0;
    int watchdog_cycles = 200;
    bit table_ready = 1'b0;

    pwm_chain pwm_chain_inst (
        .clock(clock),
        .reset(reset),
        .sb_address(sb_address),
        .sb_write_data(sb_write_data),
        .sb_write_strobe(sb_write_strobe),
        .sb_ready(sb_ready),
        .gate_high(gate_high),
        .gate_low(gate_low)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        wait (table_ready);
        #(watchdog_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic int period_of(input int start, input int stop, input int mode);
        if (mode == mode_updown) begin
            return 2 * (stop - start);
        end
        return stop - start + 1;
    endfunction

    // Cycles per period whose count lies in [low, high)
    function automatic int window_cycles(input int start, input int stop, input int mode,
                                         input int low, input int high);
        int total;
        int value;
        total = 0;
        for (value = start; value <= stop; value++) begin
            if (value >= low && value < high) begin
                // Up-down passes the inner counts twice, the turning points once
                if (mode == mode_updown && value != start && value != stop) begin
                    total += 2;
                end else begin
                    total += 1;
                end
            end
        end
        return total;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic check_value(input int got, input int expected, input string what);
        assert (got == expected) else begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic bus_write(input logic [bus_width-1:0] address,
                             input logic [bus_width-1:0] data, input bit stray = 1'b0);
        int busy_edges;
        busy_edges = 0;
        while (!sb_ready) next_cycle();
        sb_address = address;
        sb_write_data = data;
        sb_write_strobe = 1'b1;
        next_cycle();
        if (stray) begin
            // Second strobe with other data while the bus is busy
            sb_write_data = '0;
            next_cycle();
            busy_edges = 1;
        end
        sb_write_strobe = 1'b0;
        while (!sb_ready && busy_edges < 8) begin
            next_cycle();
            busy_edges++;
        end
        check_value(busy_edges, 2, "sb_ready low edges after a strobe");
    endtask

    task automatic measure_period(input int period);
        int cycle;
        int ch;
        for (ch = 0; ch < n_channels; ch++) begin
            high_seen[ch] = 0;
            low_seen[ch] = 0;
        end
        for (cycle = 0; cycle < period; cycle++) begin
            next_cycle();
            for (ch = 0; ch < n_channels; ch++) begin
                high_seen[ch] += int'(gate_high[ch]);
                low_seen[ch] += int'(gate_low[ch]);
            end
        end
    endtask

    // Cycles between two rising edges of gate_high[0]
    task automatic measure_spacing(output int spacing);
        logic prev;
        prev = gate_high[0];
        while (!(gate_high[0] && !prev)) begin
            prev = gate_high[0];
            next_cycle();
        end
        spacing = 0;
        do begin
            prev = gate_high[0];
            next_cycle();
            spacing++;
        end while (!(gate_high[0] && !prev));
    endtask

    task automatic run_row(input int r);
        logic [bus_width-1:0] control_value;
        int ch;
        int spacing;
        control_value = '0;
        control_value[ctl_mode_lsb +: 3] = rows[r].mode[2:0];
        control_value[ctl_dc_bit] = rows[r].dc[0];
        // First write stops the counter, the second lands the mode once idle
        bus_write(base_address + reg_control, control_value);
        bus_write(base_address + reg_control, control_value);
        for (ch = 0; ch < n_channels; ch++) begin
            bus_write(base_address + reg_cmp_low_0 + 4 * ch, rows[r].low[ch]);
            bus_write(base_address + reg_cmp_high_0 + 4 * ch, rows[r].high[ch]);
            bus_write(base_address + reg_deadtime_0 + 4 * ch, rows[r].deadtime);
        end
        bus_write(base_address + reg_start, rows[r].start);
        bus_write(base_address + reg_stop, rows[r].stop);
        bus_write(base_address + reg_shift, 32'd2);
        bus_write(base_address + reg_out_enable, rows[r].out_enable);
        bus_write(base_address + reg_dt_enable, rows[r].dt_enable);
        control_value[ctl_run_bit] = 1'b1;
        bus_write(base_address + reg_control, control_value);
        // Locked while running, the waveform must not change
        bus_write(base_address + reg_stop, rows[r].stop + 32'd7);
        bus_write(base_address + reg_deadtime_0, rows[r].deadtime + 32'd5);
        repeat (2 * rows[r].period) next_cycle();
        measure_period(rows[r].period);
        for (ch = 0; ch < n_channels; ch++) begin
            check_value(high_seen[ch], rows[r].exp_high[ch],
                        $sformatf("gate_high[%0d] cycles per period", ch));
            check_value(low_seen[ch], rows[r].exp_low[ch],
                        $sformatf("gate_low[%0d] cycles per period", ch));
        end
        // Period from pulse spacing, only where channel 0 pulses once per period
        if (rows[r].exp_high[0] > 0 && rows[r].exp_high[0] < rows[r].period &&
            (rows[r].mode != mode_updown || rows[r].dc != 0 ||
             rows[r].low[0] <= rows[r].start || rows[r].high[0] > rows[r].stop)) begin
            measure_spacing(spacing);
            check_value(spacing, rows[r].period, "period between gate_high[0] pulses");
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %-16s ok", name);
        end else begin
            failed_tests++;
            $display("test %-16s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic fill_table();
        int r;
        int ch;
        // start, stop, mode, low, high, deadtime, dt_enable, out_enable, dc, period,
        // expected high, expected low
        rows[0] = '{0, 19, 0, '{5, 0, 10}, '{15, 4, 30}, 0, 0, 'h3f, 0, 20,
                    '{10, 4, 10}, '{10, 16, 10}};
        rows[1] = '{10, 39, 1, '{12, 30, 0}, '{20, 40, 11}, 0, 0, 'h3f, 0, 30,
                    '{8, 10, 1}, '{22, 20, 29}};
        rows[2] = '{0, 15, 2, '{8, 4, 0}, '{20, 8, 2}, 0, 0, 'h3f, 0, 30,
                    '{15, 8, 3}, '{15, 22, 27}};
        rows[3] = '{0, 29, 0, '{5, 0, 10}, '{15, 2, 25}, 3, 7, 'h3f, 0, 30,
                    '{7, 0, 12}, '{17, 25, 12}};
        rows[4] = '{0, 19, 0, '{5, 0, 10}, '{15, 4, 30}, 0, 0, 'h13, 0, 20,
                    '{10, 0, 10}, '{10, 0, 0}};
        rows[5] = '{5, 25, 0, '{1, 2, 3}, '{4, 5, 6}, 0, 0, 'h3f, 1, 40,
                    '{39, 39, 39}, '{1, 1, 1}};
        row_names = '{"up mode", "down mode", "up-down mode", "dead time",
                      "output enables", "duty cycle", "random up", "random up-down"};
        for (r = 6; r < n_rows; r++) begin
            rows[r] = '0;
            rows[r].stop = (r == 6) ? 16'd31 : 16'd23;
            rows[r].mode = (r == 6) ? 16'(mode_up) : 16'(mode_updown);
            rows[r].out_enable = 16'h3f;
            rows[r].period = 16'(period_of(rows[r].start, rows[r].stop, rows[r].mode));
            for (ch = 0; ch < n_channels; ch++) begin
                rows[r].low[ch] = 16'($urandom % (rows[r].stop + 1));
                rows[r].high[ch] = 16'($urandom % (rows[r].stop + 2));
                rows[r].exp_high[ch] = 16'(window_cycles(rows[r].start, rows[r].stop,
                    rows[r].mode, rows[r].low[ch], rows[r].high[ch]));
                rows[r].exp_low[ch] = rows[r].period - rows[r].exp_high[ch];
            end
        end
    endtask

    initial begin
        int first_errors;
        int r;
        reset = 1'b0;
        sb_address = '0;
        sb_write_data = '0;
        sb_write_strobe = 1'b0;
        void'($urandom(32'h01556477));
        fill_table();
        // Bus traffic, settling, measurement and spacing per row
        for (r = 0; r < n_rows; r++) begin
            watchdog_cycles += 6 * rows[r].period + bus_cycles_per_row;
        end
        table_ready = 1'b1;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b1;

        // Enables come up over the bus, a busy strobe and an unknown address change nothing
        first_errors = error_count;
        check_value(gate_high | gate_low, 0, "gate outputs after reset");
        bus_write(base_address + reg_out_enable, 32'h3f);
        repeat (3) next_cycle();
        check_value(gate_high, 3'b111, "gate_high with reset windows");
        bus_write(base_address + reg_out_enable, 32'h3f, 1'b1);
        // Low byte matches the output-enable offset, so a short decode would clear them
        bus_write(base_address + 32'h130, 32'h0);
        repeat (3) next_cycle();
        check_value(gate_high, 3'b111, "gate_high after busy strobe and unknown address");
        report_test("bus timing", first_errors);

        for (r = 0; r < n_rows; r++) begin
            first_errors = error_count;
            run_row(r);
            report_test(row_names[r], first_errors);
        end

        $display("%0d tests, %0d failed, %0d check errors", n_rows + 1, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/pwm_chain_pkg.sv
logic/chain_regs_pkg.sv
logic/chain_control_unit.sv
logic/pwm_counter.sv
logic/pwm_comparator.sv
logic/deadtime_generator.sv
logic/pwm_chain.sv
bench/pwm_chain_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the PWM chain testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pwm_chain_tb -f tb.f

output=$(./obj_dir/Vpwm_chain_tb)
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
